// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_core
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_core.sv ====
`timescale 1ns/1ns

module tb_core import rv_pkg::*;;

	typedef struct packed {
		logic [2:0] test;
		logic [1:0] kind;
		logic [4:0] waddr;
		logic [31:0] word;
		logic [31:0] value;
		logic [31:0] maddr;
	} row_t;

	// Row kinds: 0 retires nothing, 1 retires, 2 stores
	localparam int k_ret = 1;
	localparam int k_store = 2;

	logic clk = 1'b0;
	logic rst;
	logic [31:0] pc;
	logic inst_req_valid;
	logic inst_req_ready;
	logic [31:0] instruction;
	logic inst_valid;
	logic inst_ready;
	mem_req_t mem_req;
	logic mem_req_ready;
	logic [31:0] read_data;
	logic read_data_valid;
	logic read_data_ready;
	retire_t retire;

	row_t prog[$];
	logic [31:0] st_addr_q[$];
	logic [31:0] st_data_q[$];
	logic [31:0] dmem [64];
	logic [31:0] seed = 32'h3cc7_47b4;
	string test_name [1:5];
	int test_err [1:5];
	int cur_test = 1;
	int err_count = 0;
	int check_count = 0;
	int limit = 0;
	int cycles = 0;

	// Instruction and data channel model state
	logic ireq_fire, irsp_fire, ifetch_pending;
	logic [31:0] fetch_pc, ifetch_addr;
	int ireq_stall = 0;
	int irsp_wait = 0;
	logic mreq_fire, rd_fire, held, rd_pending;
	mem_req_t mreq, mreq_prev;
	logic [31:0] rd_addr;
	int mreq_stall = 0;
	int rd_wait = 0;

	always #4 clk = ~clk;

	rv_core DUT (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.inst_req_valid(inst_req_valid),
		.inst_req_ready(inst_req_ready),
		.instruction(instruction),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.mem_req(mem_req),
		.mem_req_ready(mem_req_ready),
		.read_data(read_data),
		.read_data_valid(read_data_valid),
		.read_data_ready(read_data_ready),
		.retire(retire)
	);

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int stall_cycles();
		logic [31:0] r;
		r = lcg_next();
		return int'(r[17:16]);
	endfunction

	// Every bit of the word index shows up in the pattern
	function automatic logic [31:0] fill_word(input int idx);
		logic [15:0] a;
		a = 16'(idx);
		return {~a, a} ^ 32'h5a00_00a5;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return enc_i(imm, rs1, 3'b000, rd, 7'h13);
	endfunction

	task automatic put(input int kind, input logic [31:0] word, input logic [4:0] waddr,
		input logic [31:0] value, input logic [31:0] maddr);
		row_t r;
		r.test = 3'(cur_test);
		r.kind = 2'(kind);
		r.word = word;
		r.waddr = waddr;
		r.value = value;
		r.maddr = maddr;
		prog.push_back(r);
	endtask

	// Taken branches skip a nop and a filler, not-taken ones run the nop only
	task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input bit taken, input logic [11:0] mark);
		put(0, enc_b(13'd12, rs2, rs1, f3), 5'd0, 32'd0, 32'd0);
		put(0, 32'h0, 5'd0, 32'd0, 32'd0);
		if (taken) begin
			put(0, addi(5'd21, 5'd0, 12'hfff), 5'd0, 32'd0, 32'd0);
		end
		put(k_ret, addi(5'd22, 5'd0, mark), 5'd22, 32'(mark), 32'd0);
	endtask

	task automatic build_program();
		cur_test = 1;
		put(k_ret, addi(5'd1, 5'd0, 12'd7), 5'd1, 32'd7, 0);
		put(k_ret, addi(5'd2, 5'd0, 12'hffd), 5'd2, 32'hffff_fffd, 0);
		put(k_ret, enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'd4, 0);
		put(k_ret, enc_r(7'h20, 3'b000, 5'd4, 5'd1, 5'd2), 5'd4, 32'd10, 0);
		put(k_ret, enc_r(7'h00, 3'b111, 5'd5, 5'd1, 5'd2), 5'd5, 32'd5, 0);
		put(k_ret, enc_r(7'h00, 3'b110, 5'd6, 5'd1, 5'd2), 5'd6, 32'hffff_ffff, 0);
		put(k_ret, enc_r(7'h00, 3'b100, 5'd7, 5'd1, 5'd2), 5'd7, 32'hffff_fffa, 0);
		put(k_ret, enc_r(7'h00, 3'b010, 5'd8, 5'd2, 5'd1), 5'd8, 32'd1, 0);
		put(k_ret, enc_r(7'h00, 3'b011, 5'd9, 5'd2, 5'd1), 5'd9, 32'd0, 0);
		put(k_ret, enc_i(12'hfff, 5'd1, 3'b100, 5'd10, 7'h13), 5'd10, 32'hffff_fff8, 0);
		put(k_ret, enc_i(12'd0, 5'd2, 3'b010, 5'd11, 7'h13), 5'd11, 32'd1, 0);
		put(k_ret, enc_i(12'd8, 5'd1, 3'b011, 5'd12, 7'h13), 5'd12, 32'd1, 0);
		put(k_ret, enc_i(12'h0f0, 5'd2, 3'b111, 5'd13, 7'h13), 5'd13, 32'h0000_00f0, 0);
		put(k_ret, enc_i(12'h100, 5'd1, 3'b110, 5'd14, 7'h13), 5'd14, 32'h0000_0107, 0);
		cur_test = 2;
		put(k_ret, {20'h12345, 5'd15, 7'h37}, 5'd15, 32'h1234_5000, 0);
		put(k_ret, {20'h00001, 5'd16, 7'h17}, 5'd16, 32'd60 + 32'h1000, 0);
		// jal at 64 lands on 76, jalr to 93 lands on 92
		put(k_ret, enc_j(21'd12, 5'd17), 5'd17, 32'd68, 0);
		put(0, addi(5'd21, 5'd0, 12'hfff), 5'd0, 32'd0, 0);
		put(0, addi(5'd21, 5'd0, 12'hfff), 5'd0, 32'd0, 0);
		put(k_ret, addi(5'd18, 5'd0, 12'd93), 5'd18, 32'd93, 0);
		put(k_ret, enc_i(12'd0, 5'd18, 3'b000, 5'd19, 7'h67), 5'd19, 32'd84, 0);
		put(0, addi(5'd21, 5'd0, 12'hfff), 5'd0, 32'd0, 0);
		put(0, addi(5'd21, 5'd0, 12'hfff), 5'd0, 32'd0, 0);
		put(k_ret, addi(5'd20, 5'd0, 12'd1), 5'd20, 32'd1, 0);
		cur_test = 3;
		branch_case(3'b000, 5'd1, 5'd1, 1'b1, 12'd1);
		branch_case(3'b000, 5'd1, 5'd2, 1'b0, 12'd2);
		branch_case(3'b001, 5'd1, 5'd2, 1'b1, 12'd3);
		branch_case(3'b001, 5'd1, 5'd1, 1'b0, 12'd4);
		branch_case(3'b100, 5'd2, 5'd1, 1'b1, 12'd5);
		branch_case(3'b100, 5'd1, 5'd2, 1'b0, 12'd6);
		branch_case(3'b101, 5'd1, 5'd2, 1'b1, 12'd7);
		branch_case(3'b101, 5'd2, 5'd1, 1'b0, 12'd8);
		branch_case(3'b110, 5'd1, 5'd2, 1'b1, 12'd9);
		branch_case(3'b110, 5'd2, 5'd1, 1'b0, 12'd10);
		branch_case(3'b111, 5'd2, 5'd1, 1'b1, 12'd11);
		branch_case(3'b111, 5'd1, 5'd2, 1'b0, 12'd12);
		cur_test = 4;
		put(k_store, enc_s(12'd16, 5'd15, 5'd0), 5'd0, 32'h1234_5000, 32'd16);
		put(k_ret, enc_i(12'd16, 5'd0, 3'b010, 5'd24, 7'h03), 5'd24, 32'h1234_5000, 0);
		// Base 7 plus 9 gives the same word
		put(k_ret, enc_i(12'd9, 5'd1, 3'b010, 5'd25, 7'h03), 5'd25, 32'h1234_5000, 0);
		put(k_store, enc_s(12'd20, 5'd6, 5'd0), 5'd0, 32'hffff_ffff, 32'd20);
		put(k_ret, enc_i(12'd20, 5'd0, 3'b010, 5'd26, 7'h03), 5'd26, 32'hffff_ffff, 0);
		put(k_ret, enc_i(12'd32, 5'd0, 3'b010, 5'd27, 7'h03), 5'd27, fill_word(8), 0);
		cur_test = 5;
		put(k_ret, addi(5'd0, 5'd1, 12'd5), 5'd0, 32'd12, 0);
		put(k_ret, enc_r(7'h00, 3'b000, 5'd28, 5'd0, 5'd0), 5'd28, 32'd0, 0);
		put(k_store, enc_s(12'd4, 5'd7, 5'd3), 5'd0, 32'hffff_fffa, 32'd8);
		put(k_ret, enc_i(12'd8, 5'd0, 3'b010, 5'd29, 7'h03), 5'd29, 32'hffff_fffa, 0);
		// Final jump to itself
		put(k_ret, enc_j(21'd0, 5'd0), 5'd0, 32'(prog.size() * 4 + 4), 0);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("error t=%0t %s got %h expected %h", $time, name, got, exp);
			err_count++;
			test_err[cur_test]++;
		end
	endtask

	task automatic fail_note(input string what);
		$display("t=%0t %s", $time, what);
		err_count++;
		test_err[cur_test]++;
	endtask

	task automatic wait_retire();
		do begin
			@(negedge clk);
		end while (retire.wen !== 1'b1);
	endtask

	// Instruction channel
	always begin
		@(negedge clk);
		ireq_fire = !rst && inst_req_valid && inst_req_ready;
		irsp_fire = !rst && inst_valid && inst_ready;
		fetch_pc = pc;
		@(posedge clk);
		#1;
		if (irsp_fire) begin
			inst_valid = 1'b0;
		end
		if (ireq_fire) begin
			ifetch_pending = 1'b1;
			ifetch_addr = fetch_pc;
			irsp_wait = stall_cycles();
			ireq_stall = stall_cycles();
		end
		if (ireq_stall > 0) begin
			inst_req_ready = 1'b0;
			// Stall runs down only while the next request waits
			if (inst_req_valid) begin
				ireq_stall--;
			end
		end else begin
			inst_req_ready = !rst;
		end
		if (ifetch_pending && !inst_valid) begin
			if (irsp_wait > 0) begin
				irsp_wait--;
			end else begin
				instruction = (ifetch_addr[31:2] < prog.size()) ?
					prog[ifetch_addr[31:2]].word : 32'h0;
				inst_valid = 1'b1;
				ifetch_pending = 1'b0;
			end
		end
	end

	// Data channel
	always begin
		@(negedge clk);
		mreq = mem_req;
		rd_fire = !rst && read_data_valid && read_data_ready;
		if (held) begin
			check("mem_req.read", 32'(mreq.read), 32'(mreq_prev.read));
			check("mem_req.write", 32'(mreq.write), 32'(mreq_prev.write));
			check("mem_req.addr", mreq.addr, mreq_prev.addr);
			check("mem_req.wdata", mreq.wdata, mreq_prev.wdata);
		end
		held = !rst && (mreq.read || mreq.write) && !mem_req_ready;
		mreq_prev = mreq;
		mreq_fire = !rst && (mreq.read || mreq.write) && mem_req_ready;
		if (mreq_fire && mreq.write) begin
			if (st_addr_q.size() == 0) begin
				fail_note("a store was sent that the program does not contain");
			end else begin
				check("mem_req.addr", mreq.addr, st_addr_q.pop_front());
				check("mem_req.wdata", mreq.wdata, st_data_q.pop_front());
			end
			dmem[mreq.addr[7:2]] = mreq.wdata;
		end
		@(posedge clk);
		#1;
		if (rd_fire) begin
			read_data_valid = 1'b0;
		end
		if (mreq_fire) begin
			mreq_stall = stall_cycles();
			if (mreq.read) begin
				rd_pending = 1'b1;
				rd_addr = mreq.addr;
				rd_wait = stall_cycles();
			end
		end
		if (mreq_stall > 0) begin
			mem_req_ready = 1'b0;
			// Stall runs down only while the next request waits
			if (mem_req.read || mem_req.write) begin
				mreq_stall--;
			end
		end else begin
			mem_req_ready = !rst;
		end
		if (rd_pending && !read_data_valid) begin
			if (rd_wait > 0) begin
				rd_wait--;
			end else begin
				read_data = dmem[rd_addr[7:2]];
				read_data_valid = 1'b1;
				rd_pending = 1'b0;
			end
		end
	end

	// Worst case is about 12 cycles a row plus up to 5 per handshake
	initial begin
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, retirements stopped", cycles);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int i;
		rst = 1'b1;
		inst_req_ready = 1'b0;
		instruction = 32'h0;
		inst_valid = 1'b0;
		mem_req_ready = 1'b0;
		read_data = 32'h0;
		read_data_valid = 1'b0;
		ifetch_pending = 1'b0;
		rd_pending = 1'b0;
		held = 1'b0;
		test_name[1] = "arithmetic";
		test_name[2] = "upper immediates and jumps";
		test_name[3] = "branches";
		test_name[4] = "memory";
		test_name[5] = "back-pressure and x0";
		for (i = 1; i <= 5; i++) begin
			test_err[i] = 0;
		end
		for (i = 0; i < 64; i++) begin
			dmem[i] = fill_word(i);
		end
		build_program();
		for (i = 0; i < prog.size(); i++) begin
			if (prog[i].kind == 2'(k_store)) begin
				st_addr_q.push_back(prog[i].maddr);
				st_data_q.push_back(prog[i].value);
			end
		end
		limit = prog.size() * 12 + prog.size() * 20;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		for (i = 0; i < prog.size(); i++) begin
			cur_test = int'(prog[i].test);
			if (prog[i].kind == 2'(k_ret)) begin
				wait_retire();
				check("retire.waddr", 32'(retire.waddr), 32'(prog[i].waddr));
				check("retire.wdata", retire.wdata, prog[i].value);
				check("retire.pc", retire.pc, 32'(i * 4));
			end
			if (i == prog.size() - 1 || prog[i + 1].test != prog[i].test) begin
				$display("test %0d %s: %0d errors", cur_test, test_name[cur_test],
					test_err[cur_test]);
			end
		end
		if (st_addr_q.size() != 0) begin
			fail_note("some stores of the program never reached the data channel");
		end
		$display("checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ns

module rv_alu import rv_pkg::*; (
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	input  alu_op_e op,
	output logic [xlen-1:0] result,
	output logic zero
);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_xor: result = a ^ b;
			// Compare results land in bit 0
			alu_slt: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== hdl/rv_control.sv ====
`timescale 1ns/1ns

module rv_control import rv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  decoded_t dec,
	input  logic take_branch,
	input  logic inst_req_ready,
	input  logic inst_valid,
	input  logic mem_req_ready,
	input  logic read_data_valid,
	output state_e state,
	output logic inst_req_valid,
	output logic inst_ready,
	output logic read_data_ready,
	output logic mem_read,
	output logic mem_write
);

	state_e next_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rst_s;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			rst_s: next_state = fetch_s;
			fetch_s: if (inst_req_ready) next_state = inst_wait_s;
			inst_wait_s: if (inst_valid) next_state = decode_s;
			decode_s: next_state = exec_s;
			exec_s: begin
				case (dec.cls)
					cls_arith, cls_jal, cls_jalr, cls_lui, cls_auipc: next_state = write_back_s;
					cls_load: next_state = load_s;
					cls_store: next_state = store_s;
					// Branches and unknown opcodes
					default: next_state = fetch_s;
				endcase
			end
			load_s: if (mem_req_ready) next_state = read_wait_s;
			read_wait_s: if (read_data_valid) next_state = write_back_s;
			store_s: if (mem_req_ready) next_state = fetch_s;
			write_back_s: next_state = fetch_s;
			default: next_state = rst_s;
		endcase
	end

	assign inst_req_valid = (state == fetch_s);
	// Ready also in reset to drain stale responses
	assign inst_ready = (state == rst_s) || (state == inst_wait_s);
	assign read_data_ready = (state == rst_s) || (state == read_wait_s);
	assign mem_read = (state == load_s);
	assign mem_write = (state == store_s);

	a_mem_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(mem_read && mem_write));

	a_state_legal: assert property (@(posedge clk) disable iff (rst)
		state inside {rst_s, fetch_s, inst_wait_s, decode_s, exec_s,
			load_s, read_wait_s, store_s, write_back_s});

	// Redirect from the datapath only for control-flow classes in exec
	a_redirect_class: assert property (@(posedge clk) disable iff (rst)
		take_branch |-> (state == exec_s) && (dec.cls inside {cls_branch, cls_jal, cls_jalr}));

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
	input  logic clk,
	input  logic rst,
	output logic [xlen-1:0] pc,
	output logic inst_req_valid,
	input  logic inst_req_ready,
	input  logic [xlen-1:0] instruction,
	input  logic inst_valid,
	output logic inst_ready,
	output mem_req_t mem_req,
	input  logic mem_req_ready,
	input  logic [xlen-1:0] read_data,
	input  logic read_data_valid,
	output logic read_data_ready,
	output retire_t retire
);

	state_e state;
	decoded_t dec;
	logic take_branch;
	logic mem_read;
	logic mem_write;
	logic [xlen-1:0] mem_addr;
	logic [xlen-1:0] mem_wdata;

	assign mem_req.read = mem_read;
	assign mem_req.write = mem_write;
	assign mem_req.addr = mem_addr;
	assign mem_req.wdata = mem_wdata;

	rv_control u_control (
		.clk(clk),
		.rst(rst),
		.dec(dec),
		.take_branch(take_branch),
		.inst_req_ready(inst_req_ready),
		.inst_valid(inst_valid),
		.mem_req_ready(mem_req_ready),
		.read_data_valid(read_data_valid),
		.state(state),
		.inst_req_valid(inst_req_valid),
		.inst_ready(inst_ready),
		.read_data_ready(read_data_ready),
		.mem_read(mem_read),
		.mem_write(mem_write)
	);

	rv_decode u_decode (
		.clk(clk),
		.instruction(instruction),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.dec(dec)
	);

	rv_datapath u_datapath (
		.clk(clk),
		.rst(rst),
		.state(state),
		.dec(dec),
		.inst_valid(inst_valid),
		.read_data(read_data),
		.read_data_valid(read_data_valid),
		.pc(pc),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.take_branch(take_branch),
		.retire(retire)
	);

endmodule

// ==== hdl/rv_datapath.sv ====
`timescale 1ns/1ns

module rv_datapath import rv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  state_e state,
	input  decoded_t dec,
	input  logic inst_valid,
	input  logic [xlen-1:0] read_data,
	input  logic read_data_valid,
	output logic [xlen-1:0] pc,
	output logic [xlen-1:0] mem_addr,
	output logic [xlen-1:0] mem_wdata,
	output logic take_branch,
	output retire_t retire
);

	logic [xlen-1:0] inst_pc;
	logic [xlen-1:0] op_a_q;
	logic [xlen-1:0] op_b_q;
	logic [xlen-1:0] result_q;
	logic [xlen-1:0] load_q;
	logic [xlen-1:0] rdata1;
	logic [xlen-1:0] rdata2;
	logic [xlen-1:0] alu_a;
	logic [xlen-1:0] alu_b;
	alu_op_e alu_op;
	logic [xlen-1:0] alu_result;
	logic alu_zero;
	logic branch_cond;
	logic [xlen-1:0] branch_target;
	logic [xlen-1:0] next_target;
	logic rf_wen;
	logic [xlen-1:0] rf_wdata;

	// One ALU serves pc+4, execution and the link value
	always_comb begin
		case (state)
			inst_wait_s: begin
				alu_a = pc;
				alu_b = xlen'(4);
				alu_op = alu_add;
			end
			write_back_s: begin
				alu_a = inst_pc;
				alu_b = xlen'(4);
				alu_op = alu_add;
			end
			default: begin
				alu_a = op_a_q;
				alu_b = op_b_q;
				alu_op = dec.alu_op;
			end
		endcase
	end

	rv_alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(alu_op),
		.result(alu_result),
		.zero(alu_zero)
	);

	rv_regfile u_regfile (
		.clk(clk),
		.raddr1(dec.rs1),
		.raddr2(dec.rs2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.wen(rf_wen),
		.waddr(dec.rd),
		.wdata(rf_wdata)
	);

	// eq/ne look at zero, the rest at the slt bit
	assign branch_cond = funct3_sel(dec.funct3, alu_zero, alu_result[0]);
	assign branch_target = inst_pc + dec.imm;
	assign take_branch = (state == exec_s) &&
		((dec.cls == cls_branch && branch_cond) || dec.cls == cls_jal || dec.cls == cls_jalr);

	always_comb begin
		case (dec.cls)
			cls_branch: next_target = branch_target;
			cls_jalr: next_target = {alu_result[xlen-1:1], 1'b0};
			default: next_target = alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (state == inst_wait_s && inst_valid) begin
			pc <= alu_result;
		end else if (take_branch) begin
			pc <= next_target;
		end
	end

	always_ff @(posedge clk) begin
		if (state == inst_wait_s && inst_valid) begin
			inst_pc <= pc;
		end
		if (state == decode_s) begin
			op_a_q <= (dec.cls == cls_auipc || dec.cls == cls_jal) ? inst_pc : rdata1;
			op_b_q <= dec.src_imm ? dec.imm : rdata2;
		end
		if (state == exec_s) begin
			result_q <= alu_result;
		end
		if (state == read_wait_s && read_data_valid) begin
			load_q <= read_data;
		end
	end

	assign mem_addr = {result_q[xlen-1:2], 2'b00};
	assign mem_wdata = rdata2;

	assign rf_wen = (state == write_back_s);
	always_comb begin
		case (dec.cls)
			cls_load: rf_wdata = load_q;
			cls_lui: rf_wdata = dec.imm;
			cls_jal, cls_jalr: rf_wdata = alu_result;
			default: rf_wdata = result_q;
		endcase
	end

	assign retire.wen = rf_wen;
	assign retire.waddr = dec.rd;
	assign retire.wdata = rf_wdata;
	assign retire.pc = inst_pc;

	function automatic logic funct3_sel(input logic [2:0] f3, input logic zero,
		input logic lt);
		funct3_sel = f3[2] ? (lt ^ f3[0]) : (zero ^ f3[0]);
	endfunction

endmodule

// ==== hdl/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
	input  logic clk,
	input  logic [xlen-1:0] instruction,
	input  logic inst_valid,
	input  logic inst_ready,
	output decoded_t dec
);

	logic [xlen-1:0] inst_q;
	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	alu_op_e arith_op;

	always_ff @(posedge clk) begin
		if (inst_valid && inst_ready) begin
			inst_q <= instruction;
		end
	end

	assign opcode = opcode_e'(inst_q[6:0]);
	assign funct3 = inst_q[14:12];
	assign funct7 = inst_q[31:25];

	// funct7 only matters for sub on the register form
	always_comb begin
		case (funct3)
			3'b000: arith_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
			3'b010: arith_op = alu_slt;
			3'b011: arith_op = alu_sltu;
			3'b100: arith_op = alu_xor;
			3'b110: arith_op = alu_or;
			default: arith_op = alu_and;
		endcase
	end

	always_comb begin
		dec.funct3 = funct3;
		dec.rd = inst_q[11:7];
		dec.rs1 = inst_q[19:15];
		dec.rs2 = inst_q[24:20];
		dec.alu_op = alu_add;
		dec.src_imm = 1'b1;
		dec.cls = cls_none;
		dec.imm = {{20{inst_q[31]}}, inst_q[31:20]};
		case (opcode)
			opc_op, opc_op_imm: begin
				// Shift encodings are not supported
				if (funct3 != 3'b001 && funct3 != 3'b101) begin
					dec.cls = cls_arith;
				end
				dec.alu_op = arith_op;
				dec.src_imm = (opcode == opc_op_imm);
			end
			opc_load: dec.cls = cls_load;
			opc_store: begin
				dec.cls = cls_store;
				dec.imm = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
			end
			opc_branch: begin
				if (funct3[2:1] != 2'b01) begin
					dec.cls = cls_branch;
				end
				dec.src_imm = 1'b0;
				dec.alu_op = !funct3[2] ? alu_sub : (funct3[1] ? alu_sltu : alu_slt);
				dec.imm = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
					inst_q[11:8], 1'b0};
			end
			opc_jal: begin
				dec.cls = cls_jal;
				dec.imm = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
					inst_q[30:21], 1'b0};
			end
			opc_jalr: dec.cls = cls_jalr;
			opc_lui, opc_auipc: begin
				dec.cls = (opcode == opc_lui) ? cls_lui : cls_auipc;
				dec.imm = {inst_q[31:12], 12'b0};
			end
			default: dec.cls = cls_none;
		endcase
	end

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam logic [xlen-1:0] reset_pc = '0;

	// Controller states, one instruction at a time
	typedef enum logic [3:0] {
		rst_s,
		fetch_s,
		inst_wait_s,
		decode_s,
		exec_s,
		load_s,
		read_wait_s,
		store_s,
		write_back_s
	} state_e;

	// RV32I major opcodes kept by this core
	typedef enum logic [6:0] {
		opc_load   = 7'b0000011,
		opc_op_imm = 7'b0010011,
		opc_auipc  = 7'b0010111,
		opc_store  = 7'b0100011,
		opc_op     = 7'b0110011,
		opc_lui    = 7'b0110111,
		opc_branch = 7'b1100011,
		opc_jalr   = 7'b1100111,
		opc_jal    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu
	} alu_op_e;

	typedef enum logic [3:0] {
		cls_arith, cls_load, cls_store, cls_branch, cls_jal, cls_jalr, cls_lui, cls_auipc, cls_none
	} inst_class_e;

	typedef struct packed {
		inst_class_e cls;
		alu_op_e alu_op;
		// Second ALU operand comes from the immediate
		logic src_imm;
		logic [2:0] funct3;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [xlen-1:0] imm;
	} decoded_t;

	typedef struct packed {
		logic read;
		logic write;
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic wen;
		logic [reg_addr_w-1:0] waddr;
		logic [xlen-1:0] wdata;
		logic [xlen-1:0] pc;
	} retire_t;

endpackage

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
	input  logic clk,
	input  logic [reg_addr_w-1:0] raddr1,
	input  logic [reg_addr_w-1:0] raddr2,
	output logic [xlen-1:0] rdata1,
	output logic [xlen-1:0] rdata2,
	input  logic wen,
	input  logic [reg_addr_w-1:0] waddr,
	input  logic [xlen-1:0] wdata
);

	logic [xlen-1:0] regs [2**reg_addr_w];

	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 always reads as zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== list.f ====
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_control.sv
hdl/rv_decode.sv
hdl/rv_datapath.sv
hdl/rv_core.sv
bench/tb_core.sv
